// ==== src/dodge_macros.svh ====
// Board geometry, playfield limits, screen origin, widths and colors
// for the dodge drawing core

`ifndef DODGE_MACROS_SVH
`define DODGE_MACROS_SVH

// Board size with the wall ring included
`define DODGE_ROWS 14
`define DODGE_COLS 10

// Player limits; player row r sits on board row r+1
`define PLAY_ROW_MAX 11
`define PLAY_COL_MIN 1   // Board column next to the left wall
`define PLAY_COL_MAX 8

// Top-left pixel of the board on the 160x120 screen
`define X_ORIGIN 60
`define Y_ORIGIN 18

`define PIX_X_W 8
`define PIX_Y_W 7
`define COLOR_W 3

`define COLOR_WHITE 7
`define COLOR_BLACK 0

`endif

// ==== src/dodge_pkg.sv ====
// Shared types of the dodge core with indices, pixel coordinates, color
// and the plotter state and move enums

`include "dodge_macros.svh"

package dodge_pkg;

	typedef logic [3:0] row_idx_t;  // Board row or player row
	typedef logic [3:0] col_idx_t;  // Board column

	typedef logic [`PIX_X_W-1:0] pix_x_t;
	typedef logic [`PIX_Y_W-1:0] pix_y_t;
	typedef logic [`COLOR_W-1:0] color_t;

	// Plotter is either scanning cells or in the one-cycle frame gap
	typedef enum logic {
		plot_scan,
		plot_gap
	} plot_state_t;

	typedef enum logic [2:0] {
		move_none,
		move_up,
		move_down,
		move_left,
		move_right
	} move_t;

endpackage

// ==== src/player_control.sv ====
// Player movement with key edge detection, priority decode and the
// clamped player position register

`timescale 1ns/1ps
`include "dodge_macros.svh"

module player_control (
	input  logic                clk,
	input  logic                reset,
	input  logic                key_up,
	input  logic                key_down,
	input  logic                key_left,
	input  logic                key_right,
	output dodge_pkg::row_idx_t player_row,
	output dodge_pkg::col_idx_t player_col
);
	import dodge_pkg::*;

	logic [3:0] key_now;   // Ordered up, down, left, right from the MSB
	logic [3:0] key_prev;
	logic [3:0] key_rise;
	move_t      move;

	assign key_now  = {key_up, key_down, key_left, key_right};
	assign key_rise = key_now & ~key_prev;

	// Held high in reset so a key held through reset does not count
	always_ff @(posedge clk) begin
		if (reset)
			key_prev <= '1;
		else
			key_prev <= key_now;
	end

	// Only the highest priority rising key acts
	always_comb begin
		if (key_rise[3])
			move = move_up;
		else if (key_rise[2])
			move = move_down;
		else if (key_rise[1])
			move = move_left;
		else if (key_rise[0])
			move = move_right;
		else
			move = move_none;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			player_row <= '0;
			player_col <= col_idx_t'(`PLAY_COL_MIN);  // First column inside the wall
		end else begin
			case (move)
				move_up: begin
					if (player_row != '0)
						player_row <= player_row - 4'd1;
				end
				move_down: begin
					if (player_row != row_idx_t'(`PLAY_ROW_MAX))
						player_row <= player_row + 4'd1;
				end
				move_left: begin
					if (player_col != col_idx_t'(`PLAY_COL_MIN))
						player_col <= player_col - 4'd1;
				end
				move_right: begin
					if (player_col != col_idx_t'(`PLAY_COL_MAX))
						player_col <= player_col + 4'd1;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== src/board_map.sv ====
// Board layout of the wall ring and the player cell for the cell
// that the plotter is scanning

`timescale 1ns/1ps
`include "dodge_macros.svh"

module board_map (
	input  dodge_pkg::row_idx_t player_row,
	input  dodge_pkg::col_idx_t player_col,
	input  dodge_pkg::row_idx_t scan_row,
	input  dodge_pkg::col_idx_t scan_col,
	output logic                cell_lit
);
	import dodge_pkg::*;

	logic     on_wall;
	logic     on_player;
	row_idx_t player_board_row;

	// Player rows start one below the top wall
	assign player_board_row = player_row + 4'd1;

	// Outer ring of the 14 by 10 board
	assign on_wall = (scan_row == '0)
		|| (scan_row == row_idx_t'(`DODGE_ROWS - 1))
		|| (scan_col == '0)
		|| (scan_col == col_idx_t'(`DODGE_COLS - 1));

	assign on_player = (scan_row == player_board_row) && (scan_col == player_col);

	assign cell_lit = on_wall || on_player;  // Lit cells are drawn white

endmodule

// ==== src/square_plotter.sv ====
// Continuous board scanner that draws every cell as a 2 by 2 square
// with one registered pixel per clock and a one-cycle gap between frames

`timescale 1ns/1ps
`include "dodge_macros.svh"

module square_plotter (
	input  logic                clk,
	input  logic                reset,
	input  logic                cell_lit,
	output dodge_pkg::row_idx_t scan_row,
	output dodge_pkg::col_idx_t scan_col,
	output dodge_pkg::pix_x_t   pixel_x,
	output dodge_pkg::pix_y_t   pixel_y,
	output dodge_pkg::color_t   pixel_color,
	output logic                plot
);
	import dodge_pkg::*;

	plot_state_t state;
	logic [1:0]  sub;       // Bit 0 is dx, bit 1 is dy inside the square
	logic        last_sub;
	logic        last_col;
	logic        last_row;

	assign last_sub = (sub == 2'd3);
	assign last_col = (scan_col == col_idx_t'(`DODGE_COLS - 1));
	assign last_row = (scan_row == row_idx_t'(`DODGE_ROWS - 1));

	// Scan order is row, then column, then the four pixels of the square
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= plot_scan;
			scan_row <= '0;
			scan_col <= '0;
			sub      <= '0;
			plot     <= 1'b0;
		end else begin
			case (state)
				plot_scan: begin
					plot <= 1'b1;
					sub  <= sub + 2'd1;
					if (last_sub) begin
						if (last_col) begin
							scan_col <= '0;
							if (last_row) begin
								// Pause for one cycle after the whole board
								scan_row <= '0;
								state    <= plot_gap;
							end else begin
								scan_row <= scan_row + 4'd1;
							end
						end else begin
							scan_col <= scan_col + 4'd1;
						end
					end
				end

				plot_gap: begin
					plot  <= 1'b0;  // Counters already back at the first cell
					state <= plot_scan;
				end

				default: begin
					plot  <= 1'b0;
					state <= plot_scan;
				end
			endcase
		end
	end

	// Pixel payload follows the counters every cycle and is only valid with plot
	// Concatenating the index with the sub bit gives 2*index + offset
	always_ff @(posedge clk) begin
		pixel_x     <= pix_x_t'(`X_ORIGIN) + pix_x_t'({scan_col, sub[0]});
		pixel_y     <= pix_y_t'(`Y_ORIGIN) + pix_y_t'({scan_row, sub[1]});
		pixel_color <= cell_lit ? color_t'(`COLOR_WHITE) : color_t'(`COLOR_BLACK);
	end

endmodule

// ==== src/dodge_top.sv ====
// Top level of the dodge drawing core wiring the player control,
// the board map and the square plotter

`timescale 1ns/1ps

module dodge_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                key_up,
	input  logic                key_down,
	input  logic                key_left,
	input  logic                key_right,
	output dodge_pkg::pix_x_t   pixel_x,
	output dodge_pkg::pix_y_t   pixel_y,
	output dodge_pkg::color_t   pixel_color,
	output logic                plot,
	output dodge_pkg::row_idx_t player_row,
	output dodge_pkg::col_idx_t player_col
);
	import dodge_pkg::*;

	row_idx_t scan_row;
	col_idx_t scan_col;
	logic     cell_lit;  // Combinational answer for the cell being scanned

	player_control u_control (
		.clk        (clk),
		.reset      (reset),
		.key_up     (key_up),
		.key_down   (key_down),
		.key_left   (key_left),
		.key_right  (key_right),
		.player_row (player_row),
		.player_col (player_col)
	);

	board_map u_map (
		.player_row (player_row),
		.player_col (player_col),
		.scan_row   (scan_row),
		.scan_col   (scan_col),
		.cell_lit   (cell_lit)
	);

	square_plotter u_plotter (
		.clk         (clk),
		.reset       (reset),
		.cell_lit    (cell_lit),
		.scan_row    (scan_row),
		.scan_col    (scan_col),
		.pixel_x     (pixel_x),
		.pixel_y     (pixel_y),
		.pixel_color (pixel_color),
		.plot        (plot)
	);

endmodule

// ==== verification/dodge_tb.sv ====
// Testbench for the dodge core with clock, reset, LFSR key presses,
// a reference model of the player and the plotter, and per-cycle checks

`timescale 1ns/1ps
`include "dodge_macros.svh"

module dodge_tb;
	import dodge_pkg::*;

	localparam int PIXELS = `DODGE_ROWS * `DODGE_COLS * 4;  // Pixels in one frame

	logic clk;
	logic reset;
	logic key_up;
	logic key_down;
	logic key_left;
	logic key_right;
	pix_x_t   pixel_x;
	pix_y_t   pixel_y;
	color_t   pixel_color;
	logic     plot;
	row_idx_t player_row;
	col_idx_t player_col;

	// Model state stepped on the rising edge
	int       m_row;
	int       m_col;
	int       m_idx;
	logic [3:0] m_prev;
	logic     exp_plot;
	pix_x_t   exp_x;
	pix_y_t   exp_y;
	color_t   exp_color;
	logic     model_ready = 1'b0;
	int       frames_done = 0;
	logic [15:0] lfsr = 16'd49;

	dodge_top u_dut (
		.clk         (clk),
		.reset       (reset),
		.key_up      (key_up),
		.key_down    (key_down),
		.key_left    (key_left),
		.key_right   (key_right),
		.pixel_x     (pixel_x),
		.pixel_y     (pixel_y),
		.pixel_color (pixel_color),
		.plot        (plot),
		.player_row  (player_row),
		.player_col  (player_col)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Key priority is up, down, left, right; each move stops at the playfield edge
	function automatic void next_position(input int row, input int col, input logic [3:0] rise,
		output int new_row, output int new_col);
		new_row = row;
		new_col = col;
		if (rise[3]) begin
			if (row > 0) new_row = row - 1;
		end else if (rise[2]) begin
			if (row < `PLAY_ROW_MAX) new_row = row + 1;
		end else if (rise[1]) begin
			if (col > `PLAY_COL_MIN) new_col = col - 1;
		end else if (rise[0]) begin
			if (col < `PLAY_COL_MAX) new_col = col + 1;
		end
	endfunction

	function automatic logic cell_is_lit(input int brow, input int bcol, input int prow,
		input int pcol);
		if (brow == 0 || brow == `DODGE_ROWS - 1 || bcol == 0 || bcol == `DODGE_COLS - 1)
			return 1'b1;
		return (brow == prow + 1) && (bcol == pcol);  // Player row 0 is board row 1
	endfunction

	// The scan index counts four pixels per cell with cells in row-major order
	function automatic int scan_x(input int idx);
		return `X_ORIGIN + 2 * ((idx / 4) % `DODGE_COLS) + (idx % 2);
	endfunction

	function automatic int scan_y(input int idx);
		return `Y_ORIGIN + 2 * ((idx / 4) / `DODGE_COLS) + ((idx / 2) % 2);
	endfunction

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int count, output logic [3:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr  = lfsr_next(lfsr);
			value = {value[2:0], lfsr[0]};
		end
	endtask

	task automatic check_hex(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("error %s expected %h got %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// Keys are ordered up, down, left, right from the MSB
	task automatic press_keys(input logic [3:0] keys, input int hold);
		{key_up, key_down, key_left, key_right} = keys;
		repeat (hold) @(negedge clk);
		{key_up, key_down, key_left, key_right} = 4'b0000;
		repeat (2) @(negedge clk);
	endtask

	task automatic wait_frames(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (frames_done < count) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) begin
				$display("Timed out waiting for frame %0d of the plotter", count);
				$display("Simulation failed");
				$fatal(1);
			end
		end
	endtask

	// The reference model draws each pixel with the position from before this edge
	always @(posedge clk) begin
		logic [3:0] keys_now;
		keys_now = {key_up, key_down, key_left, key_right};
		if (reset) begin
			m_prev      = 4'hF;  // Keys held through reset must not count
			m_row       = 0;
			m_col       = `PLAY_COL_MIN;
			m_idx       = 0;
			exp_plot    = 1'b0;
			model_ready = 1'b1;
		end else begin
			if (m_idx < PIXELS) begin
				exp_x     = pix_x_t'(scan_x(m_idx));
				exp_y     = pix_y_t'(scan_y(m_idx));
				exp_color = cell_is_lit((m_idx / 4) / `DODGE_COLS, (m_idx / 4) % `DODGE_COLS,
					m_row, m_col) ? color_t'(`COLOR_WHITE) : color_t'(`COLOR_BLACK);
				exp_plot  = 1'b1;
				m_idx++;
			end else begin
				exp_plot = 1'b0;  // The single gap cycle between frames
				m_idx    = 0;
				frames_done++;
			end
			next_position(m_row, m_col, keys_now & ~m_prev, m_row, m_col);
			m_prev = keys_now;
		end
	end

	always @(negedge clk) begin
		if (model_ready) begin
			check_hex("plot", 16'(exp_plot), 16'(plot));
			check_hex("player_row", 16'(m_row), 16'(player_row));
			check_hex("player_col", 16'(m_col), 16'(player_col));
			if (exp_plot) begin
				check_hex("pixel_x", 16'(exp_x), 16'(pixel_x));
				check_hex("pixel_y", 16'(exp_y), 16'(pixel_y));
				check_hex("pixel_color", 16'(exp_color), 16'(pixel_color));
			end
		end
	end

	initial begin
		logic [3:0] pick;
		logic [3:0] long_hold;
		logic [3:0] pair;
		logic [3:0] keys;
		reset = 1'b1;
		// Right is held through reset and must not move the player afterwards
		{key_up, key_down, key_left, key_right} = 4'b0001;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		// First pixel right after reset
		check_hex("plot", 16'h1, 16'(plot));
		check_hex("pixel_x", 16'(`X_ORIGIN), 16'(pixel_x));
		check_hex("pixel_y", 16'(`Y_ORIGIN), 16'(pixel_y));
		check_hex("pixel_color", 16'(`COLOR_WHITE), 16'(pixel_color));
		check_hex("player_col", 16'(`PLAY_COL_MIN), 16'(player_col));
		{key_up, key_down, key_left, key_right} = 4'b0000;
		repeat (2) @(negedge clk);

		for (int n = 0; n < 40; n++) begin
			take_bits(2, pick);
			take_bits(1, long_hold);
			take_bits(1, pair);
			keys = 4'b1000 >> pick[1:0];
			if (pair[0])
				keys = keys | (4'b1000 >> ((pick[1:0] + 2'd1) % 4));  // Two keys rise at once
			press_keys(keys, long_hold[0] ? 4 : 1);
		end

		repeat (14) press_keys(4'b1000, 1);
		check_hex("player_row", 16'h0, 16'(player_row));
		repeat (14) press_keys(4'b0100, 1);
		check_hex("player_row", 16'(`PLAY_ROW_MAX), 16'(player_row));
		repeat (10) press_keys(4'b0010, 1);
		check_hex("player_col", 16'(`PLAY_COL_MIN), 16'(player_col));
		repeat (10) press_keys(4'b0001, 1);
		check_hex("player_col", 16'(`PLAY_COL_MAX), 16'(player_col));

		wait_frames(3, 4 * (PIXELS + 1));
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+src
src/dodge_pkg.sv
src/player_control.sv
src/board_map.sv
src/square_plotter.sv
src/dodge_top.sv
verification/dodge_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the dodge testbench with Verilator, run it and search the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module dodge_tb -f project.f -o dodge_sim > build.log 2>&1 &&
	./obj_dir/dodge_sim > sim.log 2>&1 ||
	echo "Build or simulation ended with an error, see build.log and sim.log"
grep -q "Simulation completed successfully" sim.log &&
	echo "PASS" ||
	{ echo "FAIL"; exit 1; }
